//--- verif/eeprom_testdata.txt
// columns in hex: op addr data expect test
// op 1 write, 2 read, 3 write and read strobes together, 4 write then read strobe while busy
1 123 a5 00 01
2 123 00 a5 02
1 045 11 00 03
1 145 22 00 04
1 245 33 00 05
1 745 77 00 06
2 045 00 11 07
2 745 00 77 08
2 245 00 33 09
2 145 00 22 0a
1 3ff 5c 00 0b
1 400 6d 00 0c
1 3fe 4b 00 0d
1 3ff e1 00 0e
2 3ff 00 e1 0f
2 400 00 6d 10
2 3fe 00 4b 11
3 555 9a 00 12
2 555 00 9a 13
4 0f0 3c 00 14
2 0f0 00 3c 15
1 7ff ff 00 16
2 7ff 00 ff 17
0 000 00 00 00

//--- project.f
hdl/eeprom_pkg.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_master.sv
hdl/serial_eeprom_array.sv
hdl/eeprom_sys.sv
verif/eeprom_checker.sv
verif/tb_eeprom.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_eeprom
	./obj_dir/Vtb_eeprom | tee /dev/stderr | grep "Test passed" > /dev/null

clean:
	rm -rf obj_dir

//--- verif/tb_eeprom.sv
`timescale 1ns/10ps

module tb_eeprom;

    localparam int MAX_LINES = 64;
    localparam int COLS      = 5;  // op, addr, data, expect, test

    logic                          CLK;
    logic                          RESET;
    eeprom_pkg::eeprom_req_t       req;
    logic                          busy;
    logic                          ack;
    logic [eeprom_pkg::DATA_W-1:0] rdata;
    int                            test_num;
    logic [eeprom_pkg::DATA_W-1:0] exp_data;
    int                            pass_cnt;
    int                            fail_cnt;

    logic [31:0] vec [MAX_LINES*COLS];
    int          n_lines;
    int          limit;
    int          cycles = 0;

    eeprom_sys uut (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req),
        .busy  (busy),
        .ack   (ack),
        .rdata (rdata)
    );

    eeprom_checker chk (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .busy     (busy),
        .ack      (ack),
        .rdata    (rdata),
        .test_num (test_num),
        .exp_data (exp_data),
        .pass_cnt (pass_cnt),
        .fail_cnt (fail_cnt)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: ack never came for test %0d", test_num);
            $display("Test failed");
            $finish;
        end
    end

    // inputs move 1 ns after the edge
    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic wait_ack();
        do
            next_cycle();
        while (!ack);
    endtask

    task automatic run_line(input int i);
        logic [31:0] op;
        op        = vec[i*COLS];
        test_num  = int'(vec[i*COLS+4]);
        exp_data  = vec[i*COLS+3][eeprom_pkg::DATA_W-1:0];
        req.addr  = vec[i*COLS+1][eeprom_pkg::ADDR_W-1:0];
        req.wdata = vec[i*COLS+2][eeprom_pkg::DATA_W-1:0];
        req.wr    = (op == 32'd1) || (op == 32'd3) || (op == 32'd4);
        req.rd    = (op == 32'd2) || (op == 32'd3);
        next_cycle();
        req.wr = 1'b0;
        req.rd = 1'b0;
        if (op == 32'd4)
        begin
            repeat (19) next_cycle();
            req.rd = 1'b1;  // lands while the write is running
            next_cycle();
            req.rd = 1'b0;
        end
        wait_ack();
    endtask

    initial
    begin
        CLK      = 1'b0;
        RESET    = 1'b1;
        req      = '0;
        test_num = 0;
        exp_data = '0;
        $readmemh("verif/eeprom_testdata.txt", vec);
        n_lines = 0;
        while ((n_lines < MAX_LINES) && (vec[n_lines*COLS] != 32'd0))  // op 0 ends the list
            n_lines++;
        limit = 200 * n_lines + 50;
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (4) next_cycle();  // idle bus after reset
        for (int i = 0; i < n_lines; i++)
            run_line(i);
        repeat (10) next_cycle();
        $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
        if ((fail_cnt == 0) && (pass_cnt == n_lines))
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verif/eeprom_checker.sv
`timescale 1ns/10ps

module eeprom_checker (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::eeprom_req_t       req,
    input  logic                          busy,
    input  logic                          ack,
    input  logic [eeprom_pkg::DATA_W-1:0] rdata,
    input  int                            test_num,
    input  logic [eeprom_pkg::DATA_W-1:0] exp_data,
    output int                            pass_cnt,
    output int                            fail_cnt
);

    logic [eeprom_pkg::DATA_W-1:0] model [eeprom_pkg::MEM_DEPTH];
    logic                          open_req;  // accepted and waiting for ack
    logic                          open_rd;
    logic [eeprom_pkg::ADDR_W-1:0] open_addr;
    logic [eeprom_pkg::DATA_W-1:0] open_exp;
    int                            open_test;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            open_req = 1'b0;
            pass_cnt = 0;
            fail_cnt = 0;
        end
        else
        begin
            if (ack)
            begin
                if (busy)
                begin
                    $display("busy still high while ack pulsed");
                    fail_cnt++;
                end
                if (!open_req)
                begin
                    $display("ack pulsed with no request outstanding");
                    fail_cnt++;
                end
                else if (!open_rd)
                begin
                    $display("test %0d: write acknowledged", open_test);
                    pass_cnt++;
                end
                else if (rdata !== open_exp)
                begin
                    $display("ERR test %0d: expected %02h actual %02h",
                             open_test, open_exp, rdata);
                    fail_cnt++;
                end
                else if (model[open_addr] !== open_exp)
                begin
                    // the file and the write history disagree
                    $display("test %0d: data file expects %02h but the writes left %02h",
                             open_test, open_exp, model[open_addr]);
                    fail_cnt++;
                end
                else
                begin
                    $display("test %0d: read %02h ok", open_test, rdata);
                    pass_cnt++;
                end
                open_req = 1'b0;
            end
            else if (busy && !open_req)
            begin
                $display("busy is high with no request accepted");
                fail_cnt++;
            end
            else if (!busy && open_req)
            begin
                $display("busy went low before ack came for test %0d", open_test);
                fail_cnt++;
            end
            if (!busy && (req.wr || req.rd))
            begin
                open_req  = 1'b1;
                open_rd   = !req.wr;  // write wins
                open_addr = req.addr;
                open_exp  = exp_data;
                open_test = test_num;
                if (req.wr)
                    model[req.addr] = req.wdata;
            end
        end
    end

endmodule

//--- hdl/eeprom_sys.sv
`timescale 1ns/10ps

module eeprom_sys (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::eeprom_req_t       req,
    output logic                          busy,
    output logic                          ack,
    output logic [eeprom_pkg::DATA_W-1:0] rdata
);

    eeprom_pkg::bit_cmd_t          cmd;
    logic                          done;
    logic [eeprom_pkg::DATA_W-1:0] rx_byte;
    logic                          scl;
    logic                          sda;
    logic                          master_sda_low;
    logic                          slave_sda_low;

    assign sda = !(master_sda_low || slave_sda_low);  // pulled up unless someone pulls low

    eeprom_master u_master (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .busy    (busy),
        .ack     (ack),
        .rdata   (rdata),
        .cmd     (cmd),
        .done    (done),
        .rx_byte (rx_byte)
    );

    i2c_bit_engine u_engine (
        .CLK            (CLK),
        .RESET          (RESET),
        .cmd            (cmd),
        .done           (done),
        .rx_byte        (rx_byte),
        .scl            (scl),
        .master_sda_low (master_sda_low),
        .sda            (sda)
    );

    serial_eeprom_array u_array (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .slave_sda_low (slave_sda_low)
    );

endmodule

//--- hdl/serial_eeprom_array.sv
`timescale 1ns/10ps

module serial_eeprom_array (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic slave_sda_low
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_WDATA,
        S_RDATA
    } slv_state_e;

    slv_state_e                          state;
    logic                                scl_d;
    logic                                sda_d;
    logic                                start_det;
    logic                                stop_det;
    logic                                scl_rise;
    logic                                scl_fall;
    logic                                receiving;
    logic                                shift_in;
    logic                                byte_end;
    logic                                dev_match;
    logic                                mem_we;
    logic                                ack_slot;  // slave holds sda low
    logic [eeprom_pkg::BIT_CNT_W-1:0]    bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0]       rx_sh;
    logic [eeprom_pkg::DATA_W-1:0]       tx_sh;
    logic [eeprom_pkg::HI_ADDR_W-1:0]    hi_addr;
    logic [eeprom_pkg::DATA_W-1:0]       lo_addr;
    logic [eeprom_pkg::DATA_W-1:0]       mem [eeprom_pkg::MEM_DEPTH];

    assign start_det = scl && scl_d && sda_d && !sda;
    assign stop_det  = scl && scl_d && !sda_d && sda;
    assign scl_rise  = scl && !scl_d;
    assign scl_fall  = !scl && scl_d;

    assign receiving = (state == S_CTRL) || (state == S_ADDR) || (state == S_WDATA);
    assign shift_in  = scl_rise && receiving && !ack_slot && (bit_cnt != eeprom_pkg::ACK_SLOT);
    assign byte_end  = scl_fall && receiving && !ack_slot && (bit_cnt == eeprom_pkg::ACK_SLOT);
    assign dev_match = rx_sh[eeprom_pkg::DATA_W-1 -: 4] == eeprom_pkg::DEV_CODE;
    assign mem_we    = byte_end && (state == S_WDATA);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= S_IDLE;
            scl_d         <= 1'b1;
            sda_d         <= 1'b1;
            bit_cnt       <= '0;
            ack_slot      <= 1'b0;
            slave_sda_low <= 1'b0;
        end
        else
        begin
            scl_d <= scl;
            sda_d <= sda;
            if (start_det)
            begin
                state         <= S_CTRL;
                bit_cnt       <= '0;
                ack_slot      <= 1'b0;
                slave_sda_low <= 1'b0;
            end
            else if (stop_det)
            begin
                state         <= S_IDLE;
                ack_slot      <= 1'b0;
                slave_sda_low <= 1'b0;
            end
            else if (shift_in)
                bit_cnt <= bit_cnt + 1'b1;
            else if (scl_fall)
            begin
                if (state == S_RDATA)
                begin
                    ack_slot <= 1'b0;
                    if (bit_cnt != eeprom_pkg::ACK_SLOT)
                    begin
                        slave_sda_low <= !tx_sh[eeprom_pkg::DATA_W-1];
                        bit_cnt       <= bit_cnt + 1'b1;
                    end
                    else
                    begin
                        slave_sda_low <= 1'b0;  // master nacks, wait for stop
                        state         <= S_IDLE;
                    end
                end
                else if (ack_slot)
                begin
                    ack_slot      <= 1'b0;
                    slave_sda_low <= 1'b0;
                end
                else if (byte_end)
                begin
                    bit_cnt <= '0;
                    if ((state != S_CTRL) || dev_match)
                    begin
                        ack_slot      <= 1'b1;
                        slave_sda_low <= 1'b1;
                    end
                    case (state)
                        S_CTRL:  state <= !dev_match ? S_IDLE :
                                          rx_sh[0] ? S_RDATA : S_ADDR;
                        S_ADDR:  state <= S_WDATA;
                        default: state <= S_IDLE;  // byte stored
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (shift_in)
            rx_sh <= {rx_sh[eeprom_pkg::DATA_W-2:0], sda};
        if (byte_end && (state == S_CTRL))
        begin
            hi_addr <= rx_sh[eeprom_pkg::HI_ADDR_W:1];
            tx_sh   <= mem[{rx_sh[eeprom_pkg::HI_ADDR_W:1], lo_addr}];
        end
        else if (scl_fall && (state == S_RDATA) && (bit_cnt != eeprom_pkg::ACK_SLOT))
            tx_sh <= {tx_sh[eeprom_pkg::DATA_W-2:0], 1'b0};
        if (byte_end && (state == S_ADDR))
            lo_addr <= rx_sh;
        if (mem_we)
            mem[{hi_addr, lo_addr}] <= rx_sh;
    end

    assert property (@(posedge CLK) disable iff (RESET)
        (slave_sda_low != $past(slave_sda_low)) |-> !scl)
        else $error("slave sda changed with scl high");

endmodule

//--- hdl/eeprom_master.sv
`timescale 1ns/10ps

module eeprom_master (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::eeprom_req_t       req,
    output logic                          busy,
    output logic                          ack,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output eeprom_pkg::bit_cmd_t          cmd,
    input  logic                          done,
    input  logic [eeprom_pkg::DATA_W-1:0] rx_byte
);

    typedef enum logic [3:0] {
        M_IDLE,
        M_START,
        M_CTRL_WR,
        M_ADDR,
        M_DATA_WR,
        M_RESTART,
        M_CTRL_RD,
        M_DATA_RD,
        M_STOP,
        M_FINISH
    } mst_state_e;

    mst_state_e                    state;
    logic                          is_rd;
    logic                          accept;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0] wdata_q;

    assign accept = (state == M_IDLE) && (req.wr || req.rd);

    function automatic eeprom_pkg::bit_cmd_t step(input eeprom_pkg::bit_op_e op,
                                                  input logic [eeprom_pkg::DATA_W-1:0] b);
        eeprom_pkg::bit_cmd_t c;
        c.op      = op;
        c.tx_byte = b;
        c.go      = 1'b1;
        return c;
    endfunction

    // 1010, a10..a8, r/w
    function automatic logic [eeprom_pkg::DATA_W-1:0] ctrl_byte(
        input logic [eeprom_pkg::HI_ADDR_W-1:0] hi,
        input logic                             rd);
        return {eeprom_pkg::DEV_CODE, hi, rd};
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= M_IDLE;
            busy  <= 1'b0;
            ack   <= 1'b0;
            is_rd <= 1'b0;
            cmd   <= '0;
        end
        else
        begin
            cmd.go <= 1'b0;
            ack    <= 1'b0;
            case (state)
                M_IDLE:
                    if (accept)
                    begin
                        is_rd <= !req.wr;  // write wins
                        busy  <= 1'b1;
                        cmd   <= step(eeprom_pkg::OP_START, '0);
                        state <= M_START;
                    end
                M_START:
                    if (done)
                    begin
                        cmd   <= step(eeprom_pkg::OP_WRITE, ctrl_byte(addr_q[10:8], 1'b0));
                        state <= M_CTRL_WR;
                    end
                M_CTRL_WR:
                    if (done)
                    begin
                        cmd   <= step(eeprom_pkg::OP_WRITE, addr_q[7:0]);
                        state <= M_ADDR;
                    end
                M_ADDR:
                    if (done)
                    begin
                        if (is_rd)
                        begin
                            cmd   <= step(eeprom_pkg::OP_START, '0);  // repeated start
                            state <= M_RESTART;
                        end
                        else
                        begin
                            cmd   <= step(eeprom_pkg::OP_WRITE, wdata_q);
                            state <= M_DATA_WR;
                        end
                    end
                M_RESTART:
                    if (done)
                    begin
                        cmd   <= step(eeprom_pkg::OP_WRITE, ctrl_byte(addr_q[10:8], 1'b1));
                        state <= M_CTRL_RD;
                    end
                M_CTRL_RD:
                    if (done)
                    begin
                        cmd   <= step(eeprom_pkg::OP_READ_NACK, '0);
                        state <= M_DATA_RD;
                    end
                M_DATA_WR,
                M_DATA_RD:
                    if (done)
                    begin
                        cmd   <= step(eeprom_pkg::OP_STOP, '0);
                        state <= M_STOP;
                    end
                M_STOP:
                    if (done)
                        state <= M_FINISH;
                default:
                begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= M_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
        if ((state == M_FINISH) && is_rd)
            rdata <= rx_byte;  // engine still holds the read byte
    end

    // engine only takes go while idle, and it is never idle while done shows
    assert property (@(posedge CLK) disable iff (RESET) !(cmd.go && done))
        else $error("go issued in the same cycle as done");

endmodule

//--- hdl/i2c_bit_engine.sv
`timescale 1ns/10ps

module i2c_bit_engine (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::bit_cmd_t          cmd,
    output logic                          done,
    output logic [eeprom_pkg::DATA_W-1:0] rx_byte,
    output logic                          scl,
    output logic                          master_sda_low,
    input  logic                          sda
);

    typedef enum logic {
        ENG_IDLE,
        ENG_RUN
    } eng_state_e;

    eng_state_e                          state;
    eeprom_pkg::bit_op_e                 op;
    logic [eeprom_pkg::DATA_W-1:0]       tx_sh;
    logic [eeprom_pkg::PH_W-1:0]         ph;
    logic [eeprom_pkg::PH_W-1:0]         ph_next;
    logic [eeprom_pkg::BIT_CNT_W-1:0]    bit_cnt;
    logic                                edge_op;   // start or stop
    logic                                last_slot;
    logic                                sda_low_next;
    logic                                ss_active;

    assign ph_next   = ph + 1'b1;
    assign edge_op   = (op == eeprom_pkg::OP_START) || (op == eeprom_pkg::OP_STOP);
    assign last_slot = edge_op || (bit_cnt == eeprom_pkg::ACK_SLOT);
    assign ss_active = (state == ENG_RUN) && edge_op;

    // sda level for the second low cycle of a slot
    always_comb
    begin
        case (op)
            eeprom_pkg::OP_START: sda_low_next = 1'b0;  // release before scl rises
            eeprom_pkg::OP_STOP:  sda_low_next = 1'b1;
            eeprom_pkg::OP_WRITE: sda_low_next = (bit_cnt != eeprom_pkg::ACK_SLOT) &&
                                                 !tx_sh[eeprom_pkg::DATA_W-1];
            default:              sda_low_next = 1'b0;  // read bits and the nack
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state          <= ENG_IDLE;
            ph             <= '0;
            bit_cnt        <= '0;
            scl            <= 1'b1;
            master_sda_low <= 1'b0;
            done           <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                ENG_IDLE:
                    if (cmd.go)
                    begin
                        state   <= ENG_RUN;
                        ph      <= '0;
                        bit_cnt <= '0;
                        scl     <= 1'b0;
                    end
                default:
                begin
                    ph <= ph_next;  // wraps at end of slot
                    if (ph_next == eeprom_pkg::PH_DRIVE)
                        master_sda_low <= sda_low_next;
                    if (ph_next == eeprom_pkg::PH_RISE)
                        scl <= 1'b1;
                    if (ph_next == eeprom_pkg::PH_LAST)
                    begin
                        // done shows during the last cycle so the next go follows at once
                        done <= last_slot;
                        if (op == eeprom_pkg::OP_START)
                            master_sda_low <= 1'b1;  // sda falls, scl high
                        else if (op == eeprom_pkg::OP_STOP)
                            master_sda_low <= 1'b0;  // sda rises, scl high
                    end
                    if (ph == eeprom_pkg::PH_LAST)
                    begin
                        if (last_slot)
                            state <= ENG_IDLE;  // bus left with scl high
                        else
                        begin
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state == ENG_IDLE) && cmd.go)
        begin
            op    <= cmd.op;
            tx_sh <= cmd.tx_byte;
        end
        else if ((state == ENG_RUN) && (ph == eeprom_pkg::PH_LAST) &&
                 (op == eeprom_pkg::OP_WRITE))
            tx_sh <= {tx_sh[eeprom_pkg::DATA_W-2:0], 1'b0};  // msb first

        if ((state == ENG_RUN) && (ph == eeprom_pkg::PH_RISE) &&
            (op == eeprom_pkg::OP_READ_NACK) && (bit_cnt != eeprom_pkg::ACK_SLOT))
            rx_byte <= {rx_byte[eeprom_pkg::DATA_W-2:0], sda};  // mid high phase
    end

    // only start and stop may move sda while scl is high
    assert property (@(posedge CLK) disable iff (RESET)
        (master_sda_low != $past(master_sda_low)) |-> (!scl || $past(ss_active)))
        else $error("master sda changed with scl high outside start/stop");

endmodule

//--- hdl/eeprom_pkg.sv
package eeprom_pkg;

    // 24C16 style part, 2 KB
    localparam int ADDR_W    = 11;
    localparam int DATA_W    = 8;
    localparam int MEM_DEPTH = 2048;
    localparam int HI_ADDR_W = ADDR_W - DATA_W;  // carried in the control byte

    localparam logic [3:0] DEV_CODE = 4'b1010;

    // one scl bit slot is low, low, high, high
    localparam int SLOT_CYCLES = 4;
    localparam int PH_W        = $clog2(SLOT_CYCLES);

    localparam logic [PH_W-1:0] PH_DRIVE = PH_W'(1);                // sda moves here
    localparam logic [PH_W-1:0] PH_RISE  = PH_W'(SLOT_CYCLES / 2);  // first high cycle
    localparam logic [PH_W-1:0] PH_LAST  = PH_W'(SLOT_CYCLES - 1);

    // 8 data slots plus the acknowledge slot
    localparam int BIT_CNT_W = 4;
    localparam logic [BIT_CNT_W-1:0] ACK_SLOT = BIT_CNT_W'(DATA_W);

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } eeprom_req_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ_NACK
    } bit_op_e;

    typedef struct packed {
        bit_op_e           op;
        logic [DATA_W-1:0] tx_byte;
        logic              go;
    } bit_cmd_t;

endpackage
